// ==== design/axi_avst_pkg.sv ====
//------------------------------
// Bridge widths and sizing
//------------------------------
package axi_avst_pkg;

  //------------------------------
  // Bus geometry
  //------------------------------
  localparam int DATA_WIDTH  = 512;
  localparam int NUM_BYTES   = DATA_WIDTH / 8;
  localparam int EMPTY_WIDTH = $clog2(NUM_BYTES);
  // One bit wider than empty so a full beat of 64 fits
  localparam int COUNT_WIDTH = EMPTY_WIDTH + 1;
  // Avalon error and AXI tuser share one width
  localparam int ERROR_WIDTH = 10;

  //------------------------------
  // FIFO sizing
  //------------------------------
  localparam int FIFO_DEPTH_LOG2 = 4;
  localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_LOG2;

  // Beats that can still land after ready drops
  // Twice the pipe depth plus seven on RX
  localparam int RX_READY_ALLOWANCE = 9;
  // Twice the pipe depth plus five on TX
  localparam int TX_READY_ALLOWANCE = 7;

  localparam int RX_FULL_THRESHOLD = FIFO_DEPTH - RX_READY_ALLOWANCE;
  localparam int TX_FULL_THRESHOLD = FIFO_DEPTH - TX_READY_ALLOWANCE;

  // RX entry packs {data, empty, error, eop, sop}
  localparam int RX_ENTRY_WIDTH = DATA_WIDTH + EMPTY_WIDTH + ERROR_WIDTH + 2;
  // TX entry packs {tdata, tkeep, tuser, tlast}
  localparam int TX_ENTRY_WIDTH = DATA_WIDTH + NUM_BYTES + ERROR_WIDTH + 1;

  //------------------------------
  // Packet framing state
  //------------------------------
  // PKT_START means the next valid beat opens a packet
  typedef enum logic {
    PKT_START = 1'b0,
    PKT_BODY  = 1'b1
  } pkt_state_e;

endpackage

// ==== design/sync_fifo.sv ====
`timescale 1ns/100ps
//------------------------------
// Show-ahead sync FIFO
//------------------------------
module sync_fifo
  import axi_avst_pkg::*;
#(
  parameter int WIDTH          = 8,
  parameter int FULL_THRESHOLD = FIFO_DEPTH - 1
)
(
  input  logic             clk,
  input  logic             resetb_q,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             not_empty,
  output logic             almost_full
);

  // Storage array
  logic [WIDTH-1:0]           mem [FIFO_DEPTH];
  // Pointers wrap naturally at the depth
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  // Extra bit so a full FIFO reads as 16
  logic [FIFO_DEPTH_LOG2:0]   count;
  logic                       rd_fire;

  // Pop only when something is there
  assign rd_fire = rd_en & not_empty;

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  //------------------------------
  // Pointers and occupancy
  //------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetb_q)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave count alone
      case ({wr_en, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry visible with no read latency
  assign rd_data     = mem[rd_ptr];
  assign not_empty   = (count != '0);
  // Upstream stops offering once this rises
  assign almost_full = (count > FULL_THRESHOLD);

endmodule

// ==== design/keep_to_empty.sv ====
`timescale 1ns/100ps
//------------------------------
// tkeep valid byte counter
//------------------------------
module keep_to_empty
  import axi_avst_pkg::*;
(
  input  logic                   clk,
  input  logic [NUM_BYTES-1:0]   keep,
  output logic [COUNT_WIDTH-1:0] valid_count
);

  // Index of lowest set bit in a nibble
  function automatic logic [1:0] lowest_set(input logic [3:0] v);
    casez (v)
      4'b???1: return 2'd0;
      4'b??10: return 2'd1;
      4'b?100: return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  // First zero in keep marks the end of valid bytes
  logic [NUM_BYTES-1:0]   inv_keep;
  // Stage 1 over sixteen nibbles
  logic [15:0]            grp_any_q;
  logic [1:0]             grp_idx_q [16];
  // Stage 2 over four 16-bit blocks
  logic [3:0]             blk_any_d;
  logic [3:0]             blk_idx_d [4];
  logic [3:0]             blk_any_q;
  logic [3:0]             blk_idx_q [4];
  // Stage 3 final pick
  logic [1:0]             blk_sel;
  logic [COUNT_WIDTH-1:0] count_d;

  assign inv_keep = ~keep;

  always_ff @(posedge clk)
  begin
    for (int g = 0; g < 16; g++)
    begin
      grp_any_q[g] <= |inv_keep[4*g +: 4];
      grp_idx_q[g] <= lowest_set(inv_keep[4*g +: 4]);
    end
  end

  // Lowest hit nibble inside each block
  always_comb
  begin
    for (int b = 0; b < 4; b++)
    begin
      blk_any_d[b] = |grp_any_q[4*b +: 4];
      blk_idx_d[b] = {lowest_set(grp_any_q[4*b +: 4]),
                      grp_idx_q[4*b + lowest_set(grp_any_q[4*b +: 4])]};
    end
  end

  always_ff @(posedge clk)
  begin
    blk_any_q <= blk_any_d;
    blk_idx_q <= blk_idx_d;
  end

  // No zero anywhere in keep means all 64 bytes valid
  assign blk_sel = lowest_set(blk_any_q);
  assign count_d = (|blk_any_q) ? {1'b0, blk_sel, blk_idx_q[blk_sel]}
                                : COUNT_WIDTH'(NUM_BYTES);

  always_ff @(posedge clk)
  begin
    valid_count <= count_d;
  end

endmodule

// ==== design/rx_path.sv ====
`timescale 1ns/100ps
//------------------------------
// AXI-ST to Avalon-ST path
//------------------------------
module rx_path
  import axi_avst_pkg::*;
(
  input  logic                   clk,
  input  logic                   resetb_q,
  input  logic                   axi_tvalid,
  input  logic [DATA_WIDTH-1:0]  axi_tdata,
  input  logic [NUM_BYTES-1:0]   axi_tkeep,
  input  logic                   axi_tlast,
  output logic                   axi_tready,
  output logic                   avst_valid,
  output logic [DATA_WIDTH-1:0]  avst_data,
  output logic [EMPTY_WIDTH-1:0] avst_empty,
  output logic                   avst_eop,
  output logic                   avst_sop,
  output logic [ERROR_WIDTH-1:0] avst_error,
  input  logic                   avst_ready
);

  // Input register
  logic                      valid_t1;
  logic [DATA_WIDTH-1:0]     data_t1;
  logic [NUM_BYTES-1:0]      keep_t1;
  logic                      last_t1;
  // Delay line matched to encoder latency
  logic                      valid_t2;
  logic                      valid_t3;
  logic                      valid_t4;
  logic [DATA_WIDTH-1:0]     data_t2;
  logic [DATA_WIDTH-1:0]     data_t3;
  logic [DATA_WIDTH-1:0]     data_t4;
  logic                      last_t2;
  logic                      last_t3;
  logic                      last_t4;
  // Output stage
  logic                      valid_o;
  logic [DATA_WIDTH-1:0]     data_o;
  logic [EMPTY_WIDTH-1:0]    empty_o;
  logic                      eop_o;
  logic                      sop_o;
  pkt_state_e                pkt_state;
  // Encoder result lands alongside t4
  logic [COUNT_WIDTH-1:0]    valid_count;
  logic [COUNT_WIDTH-1:0]    empty_full;
  // FIFO side
  logic                      fifo_wen;
  logic [RX_ENTRY_WIDTH-1:0] fifo_din;
  logic [RX_ENTRY_WIDTH-1:0] fifo_dout;
  logic                      fifo_ren;
  logic                      fifo_afull;
  logic                      ready_q;

  //------------------------------
  // Control with reset
  //------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetb_q)
    begin
      valid_t1   <= 1'b0;
      valid_t2   <= 1'b0;
      valid_t3   <= 1'b0;
      valid_t4   <= 1'b0;
      valid_o    <= 1'b0;
      fifo_wen   <= 1'b0;
      axi_tready <= 1'b0;
      pkt_state  <= PKT_START;
    end
    else
    begin
      // Only accepted beats enter the pipe
      valid_t1   <= axi_tvalid & axi_tready;
      valid_t2   <= valid_t1;
      valid_t3   <= valid_t2;
      valid_t4   <= valid_t3;
      valid_o    <= valid_t4;
      fifo_wen   <= valid_o;
      // Pipe stage on the ready boundary
      axi_tready <= ready_q;
      // Next beat opens a packet after a last
      if (valid_t4)
      begin
        pkt_state <= last_t4 ? PKT_START : PKT_BODY;
      end
    end
  end

  // Empty bytes on the tail beat
  assign empty_full = COUNT_WIDTH'(NUM_BYTES) - valid_count;

  //------------------------------
  // Datapath
  //------------------------------
  always_ff @(posedge clk)
  begin
    data_t1  <= axi_tdata;
    keep_t1  <= axi_tkeep;
    last_t1  <= axi_tlast;
    data_t2  <= data_t1;
    last_t2  <= last_t1;
    data_t3  <= data_t2;
    last_t3  <= last_t2;
    data_t4  <= data_t3;
    last_t4  <= last_t3;
    data_o   <= data_t4;
    eop_o    <= last_t4;
    sop_o    <= valid_t4 & (pkt_state == PKT_START);
    // All-ones keep gives count 64 and empty 0
    empty_o  <= last_t4 ? empty_full[EMPTY_WIDTH-1:0] : '0;
    // Error field is zero since AXI has no source for it
    fifo_din <= {data_o, empty_o, {ERROR_WIDTH{1'b0}}, eop_o, sop_o};
    ready_q  <= ~fifo_afull;
  end

  keep_to_empty u_keep_to_empty (
    .clk         (clk),
    .keep        (keep_t1),
    .valid_count (valid_count)
  );

  sync_fifo #(
    .WIDTH          (RX_ENTRY_WIDTH),
    .FULL_THRESHOLD (RX_FULL_THRESHOLD)
  ) u_rx_fifo (
    .clk         (clk),
    .resetb_q    (resetb_q),
    .wr_en       (fifo_wen),
    .wr_data     (fifo_din),
    .rd_en       (fifo_ren),
    .rd_data     (fifo_dout),
    .not_empty   (avst_valid),
    .almost_full (fifo_afull)
  );

  // Pop on an Avalon handshake
  assign fifo_ren = avst_valid & avst_ready;
  assign {avst_data, avst_empty, avst_error, avst_eop, avst_sop} = fifo_dout;

endmodule

// ==== design/tx_path.sv ====
`timescale 1ns/100ps
//------------------------------
// Avalon-ST to AXI-ST path
//------------------------------
module tx_path
  import axi_avst_pkg::*;
(
  input  logic                   clk,
  input  logic                   resetb_q,
  input  logic                   avst_valid,
  input  logic [DATA_WIDTH-1:0]  avst_data,
  input  logic [EMPTY_WIDTH-1:0] avst_empty,
  input  logic                   avst_eop,
  input  logic [ERROR_WIDTH-1:0] avst_error,
  output logic                   avst_ready,
  output logic                   axi_tvalid,
  output logic [DATA_WIDTH-1:0]  axi_tdata,
  output logic [NUM_BYTES-1:0]   axi_tkeep,
  output logic                   axi_tlast,
  output logic [ERROR_WIDTH-1:0] axi_tuser,
  input  logic                   axi_tready
);

  // Input register
  logic                      valid_t1;
  logic [DATA_WIDTH-1:0]     data_t1;
  logic [EMPTY_WIDTH-1:0]    empty_t1;
  logic                      eop_t1;
  logic [ERROR_WIDTH-1:0]    error_t1;
  // Conversion stage
  logic                      valid_t2;
  logic [DATA_WIDTH-1:0]     data_t2;
  logic [NUM_BYTES-1:0]      keep_t2;
  logic                      last_t2;
  logic [ERROR_WIDTH-1:0]    user_t2;
  // FIFO side
  logic                      fifo_wen;
  logic [TX_ENTRY_WIDTH-1:0] fifo_din;
  logic [TX_ENTRY_WIDTH-1:0] fifo_dout;
  logic                      fifo_ren;
  logic                      fifo_afull;
  logic                      ready_q;

  //------------------------------
  // Control with reset
  //------------------------------
  always_ff @(posedge clk)
  begin
    if (!resetb_q)
    begin
      valid_t1   <= 1'b0;
      valid_t2   <= 1'b0;
      fifo_wen   <= 1'b0;
      avst_ready <= 1'b0;
    end
    else
    begin
      valid_t1   <= avst_valid & avst_ready;
      valid_t2   <= valid_t1;
      fifo_wen   <= valid_t2;
      avst_ready <= ready_q;
    end
  end

  //------------------------------
  // Datapath, no reset
  //------------------------------
  always_ff @(posedge clk)
  begin
    data_t1  <= avst_data;
    empty_t1 <= avst_empty;
    eop_t1   <= avst_eop;
    error_t1 <= avst_error;
    data_t2  <= data_t1;
    // Keep the low 64 minus empty bytes on the tail beat
    keep_t2  <= eop_t1 ? ({NUM_BYTES{1'b1}} >> empty_t1) : '1;
    last_t2  <= eop_t1;
    // Avalon error carried on tuser
    user_t2  <= error_t1;
    fifo_din <= {data_t2, keep_t2, user_t2, last_t2};
    ready_q  <= ~fifo_afull;
  end

  sync_fifo #(
    .WIDTH          (TX_ENTRY_WIDTH),
    .FULL_THRESHOLD (TX_FULL_THRESHOLD)
  ) u_tx_fifo (
    .clk         (clk),
    .resetb_q    (resetb_q),
    .wr_en       (fifo_wen),
    .wr_data     (fifo_din),
    .rd_en       (fifo_ren),
    .rd_data     (fifo_dout),
    .not_empty   (axi_tvalid),
    .almost_full (fifo_afull)
  );

  // Pop on an AXI handshake
  assign fifo_ren = axi_tvalid & axi_tready;
  assign {axi_tdata, axi_tkeep, axi_tuser, axi_tlast} = fifo_dout;

endmodule

// ==== design/axi_avst_bridge.sv ====
`timescale 1ns/100ps
//------------------------------
// AXI-ST Avalon-ST bridge top
//------------------------------
module axi_avst_bridge
  import axi_avst_pkg::*;
(
  input  logic                   clk,
  input  logic                   resetb_q,
  // RX AXI-ST in
  input  logic                   rx_axi_tvalid,
  input  logic [DATA_WIDTH-1:0]  rx_axi_tdata,
  input  logic [NUM_BYTES-1:0]   rx_axi_tkeep,
  input  logic                   rx_axi_tlast,
  output logic                   rx_axi_tready,
  // RX Avalon-ST out
  output logic                   rx_avst_valid,
  output logic [DATA_WIDTH-1:0]  rx_avst_data,
  output logic [EMPTY_WIDTH-1:0] rx_avst_empty,
  output logic                   rx_avst_eop,
  output logic                   rx_avst_sop,
  output logic [ERROR_WIDTH-1:0] rx_avst_error,
  input  logic                   rx_avst_ready,
  // TX Avalon-ST in
  input  logic                   tx_avst_valid,
  input  logic [DATA_WIDTH-1:0]  tx_avst_data,
  input  logic [EMPTY_WIDTH-1:0] tx_avst_empty,
  input  logic                   tx_avst_eop,
  input  logic [ERROR_WIDTH-1:0] tx_avst_error,
  output logic                   tx_avst_ready,
  // TX AXI-ST out
  output logic                   tx_axi_tvalid,
  output logic [DATA_WIDTH-1:0]  tx_axi_tdata,
  output logic [NUM_BYTES-1:0]   tx_axi_tkeep,
  output logic                   tx_axi_tlast,
  output logic [ERROR_WIDTH-1:0] tx_axi_tuser,
  input  logic                   tx_axi_tready
);

  // Two independent paths sharing only clock and reset
  rx_path u_rx_path (
    .clk        (clk),
    .resetb_q   (resetb_q),
    .axi_tvalid (rx_axi_tvalid),
    .axi_tdata  (rx_axi_tdata),
    .axi_tkeep  (rx_axi_tkeep),
    .axi_tlast  (rx_axi_tlast),
    .axi_tready (rx_axi_tready),
    .avst_valid (rx_avst_valid),
    .avst_data  (rx_avst_data),
    .avst_empty (rx_avst_empty),
    .avst_eop   (rx_avst_eop),
    .avst_sop   (rx_avst_sop),
    .avst_error (rx_avst_error),
    .avst_ready (rx_avst_ready)
  );

  tx_path u_tx_path (
    .clk        (clk),
    .resetb_q   (resetb_q),
    .avst_valid (tx_avst_valid),
    .avst_data  (tx_avst_data),
    .avst_empty (tx_avst_empty),
    .avst_eop   (tx_avst_eop),
    .avst_error (tx_avst_error),
    .avst_ready (tx_avst_ready),
    .axi_tvalid (tx_axi_tvalid),
    .axi_tdata  (tx_axi_tdata),
    .axi_tkeep  (tx_axi_tkeep),
    .axi_tlast  (tx_axi_tlast),
    .axi_tuser  (tx_axi_tuser),
    .axi_tready (tx_axi_tready)
  );

endmodule

// ==== test/bridge_props.sv ====
`timescale 1ns/100ps
//------------------------------
// FIFO assertions
//------------------------------
module bridge_props
  import axi_avst_pkg::*;
#(
  parameter int WIDTH = 8
)
(
  input logic                     clk,
  input logic                     resetb_q,
  input logic                     wr_en,
  input logic                     rd_en,
  input logic                     not_empty,
  input logic [FIFO_DEPTH_LOG2:0] count,
  input logic [WIDTH-1:0]         rd_data
);

  // Assertion failures so far
  int error_count = 0;

  // Ready allowance must keep writes off a full FIFO
  no_write_when_full: assert property (@(posedge clk) disable iff (!resetb_q)
    !(wr_en && count == FIFO_DEPTH))
  else
  begin
    error_count++;
    $error("FIFO written while full");
  end

  no_read_when_empty: assert property (@(posedge clk) disable iff (!resetb_q)
    !(rd_en && !not_empty))
  else
  begin
    error_count++;
    $error("FIFO read while empty");
  end

  empty_in_reset: assert property (@(posedge clk) !resetb_q |=> !not_empty)
  else
  begin
    error_count++;
    $error("FIFO not empty after reset edge");
  end

  // Stalled head entry holds
  head_stable: assert property (@(posedge clk) disable iff (!resetb_q)
    (not_empty && !rd_en) |=> (not_empty && $stable(rd_data)))
  else
  begin
    error_count++;
    $error("FIFO head changed while stalled");
  end

endmodule

bind sync_fifo bridge_props #(.WIDTH(WIDTH)) u_fifo_props (
  .clk       (clk),
  .resetb_q  (resetb_q),
  .wr_en     (wr_en),
  .rd_en     (rd_en),
  .not_empty (not_empty),
  .count     (count),
  .rd_data   (rd_data)
);

// ==== test/tb_axi_avst_bridge.sv ====
`timescale 1ns/100ps
//------------------------------
// Bridge testbench
//------------------------------
module tb_axi_avst_bridge
  import axi_avst_pkg::*;
();

  // Beats per path and wait limits in cycles
  localparam int NUM_BEATS   = 300;
  localparam int STALL_LIMIT = 500;
  localparam int RUN_LIMIT   = 20000;
  localparam int DRAIN_LIMIT = 2000;

  logic                   clk = 1'b0;
  logic                   resetb_q;
  // RX side
  logic                   rx_axi_tvalid;
  logic [DATA_WIDTH-1:0]  rx_axi_tdata;
  logic [NUM_BYTES-1:0]   rx_axi_tkeep;
  logic                   rx_axi_tlast;
  logic                   rx_axi_tready;
  logic                   rx_avst_valid;
  logic [DATA_WIDTH-1:0]  rx_avst_data;
  logic [EMPTY_WIDTH-1:0] rx_avst_empty;
  logic                   rx_avst_eop;
  logic                   rx_avst_sop;
  logic [ERROR_WIDTH-1:0] rx_avst_error;
  logic                   rx_avst_ready;
  // TX side
  logic                   tx_avst_valid;
  logic [DATA_WIDTH-1:0]  tx_avst_data;
  logic [EMPTY_WIDTH-1:0] tx_avst_empty;
  logic                   tx_avst_eop;
  logic [ERROR_WIDTH-1:0] tx_avst_error;
  logic                   tx_avst_ready;
  logic                   tx_axi_tvalid;
  logic [DATA_WIDTH-1:0]  tx_axi_tdata;
  logic [NUM_BYTES-1:0]   tx_axi_tkeep;
  logic                   tx_axi_tlast;
  logic [ERROR_WIDTH-1:0] tx_axi_tuser;
  logic                   tx_axi_tready;

  integer                 seed;
  // Scoreboards filled on input handshake
  logic [DATA_WIDTH-1:0]  rx_data_q [$];
  logic [EMPTY_WIDTH+1:0] rx_ctrl_q [$];
  logic [DATA_WIDTH-1:0]  tx_data_q [$];
  logic [NUM_BYTES-1:0]   tx_keep_q [$];
  logic [ERROR_WIDTH:0]   tx_side_q [$];
  // Source and sink bookkeeping
  int                     rx_sent;
  int                     tx_sent;
  int                     rx_left;
  int                     tx_left;
  int                     rx_stall;
  int                     tx_stall;
  int                     rx_rdy_len;
  int                     tx_rdy_len;
  int                     reset_edges;
  logic                   rx_next_sop;
  logic                   run_started;
  logic                   rx_done;
  logic                   tx_done;
  logic                   rx_dropped;
  logic                   tx_dropped;
  // Held sink beats for the stall check
  logic                   rx_hold;
  logic                   tx_hold;
  logic [DATA_WIDTH-1:0]  rx_hold_data;
  logic [EMPTY_WIDTH+1:0] rx_hold_ctrl;
  logic [DATA_WIDTH-1:0]  tx_hold_data;
  logic [NUM_BYTES-1:0]   tx_hold_keep;

  axi_avst_bridge uut (.*);

  always #2 clk = ~clk;

  //------------------------------
  // Helpers
  //------------------------------
  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] random_data();
    logic [DATA_WIDTH-1:0] d;
    for (int i = 0; i < DATA_WIDTH / 32; i++)
    begin
      d[32*i +: 32] = $random(seed);
    end
    return d;
  endfunction

  // Bytes missing from a tail beat
  function automatic logic [EMPTY_WIDTH-1:0] expected_empty(input logic [NUM_BYTES-1:0] keep,
                                                            input logic last);
    if (!last)
    begin
      return '0;
    end
    return EMPTY_WIDTH'(NUM_BYTES - $countones(keep));
  endfunction

  // Low 64 minus empty bytes kept on eop
  function automatic logic [NUM_BYTES-1:0] expected_keep(input logic [EMPTY_WIDTH-1:0] empty,
                                                         input logic eop);
    logic [NUM_BYTES-1:0] k;
    for (int i = 0; i < NUM_BYTES; i++)
    begin
      k[i] = !eop || (i < NUM_BYTES - int'(empty));
    end
    return k;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s (at %0t ns)", msg, $time);
    abort_run();
  endtask

  task automatic compare_values(input string name, input logic [DATA_WIDTH-1:0] expected,
                                input logic [DATA_WIDTH-1:0] actual);
    if (expected !== actual)
    begin
      $display("error at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  //------------------------------
  // Sources
  //------------------------------
  task drive_rx_source();
    logic [NUM_BYTES-1:0] keep;
    logic                 last;
    int                   trim;
    if (rx_axi_tvalid && rx_axi_tready)
    begin
      rx_data_q.push_back(rx_axi_tdata);
      rx_ctrl_q.push_back({expected_empty(rx_axi_tkeep, rx_axi_tlast), rx_axi_tlast,
                           rx_next_sop});
      // Beat after a last opens the next packet
      rx_next_sop = rx_axi_tlast;
      rx_stall    = 0;
    end
    if (rx_axi_tvalid && !rx_axi_tready)
    begin
      rx_stall++;
      if (rx_stall > STALL_LIMIT)
      begin
        report_failure("timeout: rx_axi_tready stayed low too long");
      end
    end
    else if (rx_left == 0 && rx_sent >= NUM_BEATS)
    begin
      rx_axi_tvalid <= 1'b0;
      rx_done = 1'b1;
    end
    else if (rand_below(4) == 0)
    begin
      rx_axi_tvalid <= 1'b0;
    end
    else
    begin
      // Packets of 1 to 4 beats
      if (rx_left == 0)
      begin
        rx_left = 1 + rand_below(4);
      end
      rx_left--;
      last = (rx_left == 0);
      keep = '1;
      // Full tail beats show up often enough to matter
      trim = (rand_below(3) == 0) ? 0 : rand_below(NUM_BYTES);
      if (last)
      begin
        keep = keep >> trim;
      end
      rx_axi_tvalid <= 1'b1;
      rx_axi_tdata  <= random_data();
      rx_axi_tkeep  <= keep;
      rx_axi_tlast  <= last;
      rx_sent++;
    end
  endtask

  task drive_tx_source();
    logic eop;
    int   empty;
    if (tx_avst_valid && tx_avst_ready)
    begin
      tx_data_q.push_back(tx_avst_data);
      tx_keep_q.push_back(expected_keep(tx_avst_empty, tx_avst_eop));
      tx_side_q.push_back({tx_avst_error, tx_avst_eop});
      tx_stall = 0;
    end
    if (tx_avst_valid && !tx_avst_ready)
    begin
      tx_stall++;
      if (tx_stall > STALL_LIMIT)
      begin
        report_failure("timeout: tx_avst_ready stayed low too long");
      end
    end
    else if (tx_left == 0 && tx_sent >= NUM_BEATS)
    begin
      tx_avst_valid <= 1'b0;
      tx_done = 1'b1;
    end
    else if (rand_below(4) == 0)
    begin
      tx_avst_valid <= 1'b0;
    end
    else
    begin
      if (tx_left == 0)
      begin
        tx_left = 1 + rand_below(4);
      end
      tx_left--;
      eop = (tx_left == 0);
      // Empty on body beats is noise the bridge must ignore
      empty = (eop && rand_below(3) == 0) ? 0 : rand_below(NUM_BYTES);
      tx_avst_valid <= 1'b1;
      tx_avst_data  <= random_data();
      tx_avst_empty <= EMPTY_WIDTH'(empty);
      tx_avst_eop   <= eop;
      tx_avst_error <= ERROR_WIDTH'(rand_below(1 << ERROR_WIDTH));
      tx_sent++;
    end
  endtask

  //------------------------------
  // Sinks
  //------------------------------
  task check_rx_sink();
    logic [EMPTY_WIDTH+1:0] ctrl;
    // Stalled beat must not move
    if (rx_hold)
    begin
      compare_values("rx_avst_valid", 1'b1, rx_avst_valid);
      compare_values("rx_avst_data", rx_hold_data, rx_avst_data);
      compare_values("rx_avst_ctrl", rx_hold_ctrl, {rx_avst_empty, rx_avst_eop, rx_avst_sop});
    end
    rx_hold      = rx_avst_valid && !rx_avst_ready;
    rx_hold_data = rx_avst_data;
    rx_hold_ctrl = {rx_avst_empty, rx_avst_eop, rx_avst_sop};
    if (rx_avst_valid && rx_avst_ready)
    begin
      if (rx_data_q.size() == 0)
      begin
        report_failure("RX beat left the bridge with none expected");
      end
      else
      begin
        ctrl = rx_ctrl_q.pop_front();
        compare_values("rx_avst_data", rx_data_q.pop_front(), rx_avst_data);
        compare_values("rx_avst_empty", ctrl[EMPTY_WIDTH+1:2], rx_avst_empty);
        compare_values("rx_avst_eop", ctrl[1], rx_avst_eop);
        compare_values("rx_avst_sop", ctrl[0], rx_avst_sop);
        compare_values("rx_avst_error", '0, rx_avst_error);
      end
    end
  endtask

  task check_tx_sink();
    logic [ERROR_WIDTH:0] side;
    if (tx_hold)
    begin
      compare_values("tx_axi_tvalid", 1'b1, tx_axi_tvalid);
      compare_values("tx_axi_tdata", tx_hold_data, tx_axi_tdata);
      compare_values("tx_axi_tkeep", tx_hold_keep, tx_axi_tkeep);
    end
    tx_hold      = tx_axi_tvalid && !tx_axi_tready;
    tx_hold_data = tx_axi_tdata;
    tx_hold_keep = tx_axi_tkeep;
    if (tx_axi_tvalid && tx_axi_tready)
    begin
      if (tx_data_q.size() == 0)
      begin
        report_failure("TX beat left the bridge with none expected");
      end
      else
      begin
        side = tx_side_q.pop_front();
        compare_values("tx_axi_tdata", tx_data_q.pop_front(), tx_axi_tdata);
        compare_values("tx_axi_tkeep", tx_keep_q.pop_front(), tx_axi_tkeep);
        compare_values("tx_axi_tuser", side[ERROR_WIDTH:1], tx_axi_tuser);
        compare_values("tx_axi_tlast", side[0], tx_axi_tlast);
      end
    end
  endtask

  // Alternate low and high stretches with lows long enough to fill a FIFO
  task pick_sink_ready();
    if (rx_rdy_len == 0)
    begin
      rx_avst_ready <= !rx_avst_ready;
      rx_rdy_len = rx_avst_ready ? 1 + rand_below(40) : 1 + rand_below(20);
    end
    else
    begin
      rx_rdy_len--;
    end
    if (tx_rdy_len == 0)
    begin
      tx_axi_tready <= !tx_axi_tready;
      tx_rdy_len = tx_axi_tready ? 1 + rand_below(40) : 1 + rand_below(20);
    end
    else
    begin
      tx_rdy_len--;
    end
  endtask

  //------------------------------
  // Per-cycle driver and monitor
  //------------------------------
  always @(posedge clk)
  begin
    // Bound FIFO assertions
    if (uut.u_rx_path.u_rx_fifo.u_fifo_props.error_count != 0 ||
        uut.u_tx_path.u_tx_fifo.u_fifo_props.error_count != 0)
    begin
      report_failure("a FIFO assertion fired");
    end
    if (!resetb_q)
    begin
      // First edge only clears the FIFO counts
      if (reset_edges > 0)
      begin
        compare_values("rx_avst_valid", 1'b0, rx_avst_valid);
        compare_values("tx_axi_tvalid", 1'b0, tx_axi_tvalid);
      end
      reset_edges++;
    end
    else
    begin
      if (!run_started)
      begin
        compare_values("rx_avst_valid", 1'b0, rx_avst_valid);
        compare_values("tx_axi_tvalid", 1'b0, tx_axi_tvalid);
        run_started = 1'b1;
      end
      if (rx_sent > 0 && !rx_axi_tready)
      begin
        rx_dropped = 1'b1;
      end
      if (tx_sent > 0 && !tx_avst_ready)
      begin
        tx_dropped = 1'b1;
      end
      check_rx_sink();
      check_tx_sink();
      drive_rx_source();
      drive_tx_source();
      pick_sink_ready();
    end
  end

  initial
  begin
    int cycles;
    seed          = 32'h9ed9;
    resetb_q      = 1'b0;
    rx_axi_tvalid = 1'b0;
    rx_axi_tdata  = '0;
    rx_axi_tkeep  = '0;
    rx_axi_tlast  = 1'b0;
    rx_avst_ready = 1'b0;
    tx_avst_valid = 1'b0;
    tx_avst_data  = '0;
    tx_avst_empty = '0;
    tx_avst_eop   = 1'b0;
    tx_avst_error = '0;
    tx_axi_tready = 1'b0;
    rx_sent       = 0;
    tx_sent       = 0;
    rx_left       = 0;
    tx_left       = 0;
    rx_stall      = 0;
    tx_stall      = 0;
    rx_rdy_len    = 0;
    tx_rdy_len    = 0;
    reset_edges   = 0;
    rx_next_sop   = 1'b1;
    run_started   = 1'b0;
    rx_done       = 1'b0;
    tx_done       = 1'b0;
    rx_dropped    = 1'b0;
    tx_dropped    = 1'b0;
    rx_hold       = 1'b0;
    tx_hold       = 1'b0;
    repeat (2) @(posedge clk);
    resetb_q <= 1'b1;
    cycles = 0;
    while (!(rx_done && tx_done))
    begin
      @(negedge clk);
      cycles++;
      if (cycles > RUN_LIMIT)
      begin
        report_failure("timeout: sources did not finish sending");
      end
    end
    cycles = 0;
    while (rx_data_q.size() != 0 || tx_data_q.size() != 0)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT)
      begin
        report_failure("timeout: scoreboards did not drain");
      end
    end
    // Quiet tail catches duplicated beats
    repeat (20) @(negedge clk);
    if (rx_dropped && tx_dropped &&
        uut.u_rx_path.u_rx_fifo.u_fifo_props.error_count == 0 &&
        uut.u_tx_path.u_tx_fifo.u_fifo_props.error_count == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      report_failure("input ready never dropped or a FIFO assertion fired");
    end
  end

endmodule

// ==== files.f ====
design/axi_avst_pkg.sv
design/sync_fifo.sv
design/keep_to_empty.sv
design/rx_path.sv
design/tx_path.sv
design/axi_avst_bridge.sv
test/bridge_props.sv
test/tb_axi_avst_bridge.sv

// ==== Bender.yml ====
package:
  name: axi_avst_bridge

sources:
  - design/axi_avst_pkg.sv
  - design/sync_fifo.sv
  - design/keep_to_empty.sv
  - design/rx_path.sv
  - design/tx_path.sv
  - design/axi_avst_bridge.sv
  - target: test
    files:
      - test/bridge_props.sv
      - test/tb_axi_avst_bridge.sv
